//--- sources.f
rtl/gf_poly_pkg.sv
rtl/operand_store.sv
rtl/mac_sequencer.sv
rtl/gf_row_mul.sv
rtl/diag_accum.sv
rtl/gf_poly_mul_top.sv
testbench/tb_gf_poly_mul.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_gf_poly_mul
FILELIST  = sources.f

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

//--- testbench/tb_gf_poly_mul.sv
`timescale 1ns/1ns

module tb_gf_poly_mul;

	import gf_poly_pkg::*;

	localparam int    DEPTH   = 4;
	localparam coef_t POLY    = 8'h1B;	// x^8+x^4+x^3+x+1
	localparam int    AW      = $clog2(DEPTH);
	localparam int    CW      = $clog2(2*DEPTH);
	localparam int    NCOEF   = DEPTH*LANES;
	localparam int    CWORDS  = 2*DEPTH;
	localparam int    LATENCY = DEPTH*DEPTH+3;
	localparam int    TIMEOUT = 2000;	// roughly three times the 15 runs of about 40 cycles

	logic          clk;
	logic          rst_b;
	logic          start;
	logic          a_we;
	logic          b_we;
	logic [AW-1:0] load_addr;
	word_t         load_data;
	logic [CW-1:0] c_rd_addr;
	logic          busy;
	logic          done;
	word_t         c_data;

	coef_t a_coef [NCOEF];
	coef_t b_coef [NCOEF];
	word_t exp_c [CWORDS];	// expected C contents
	int    cycle_cnt = 0;
	int    run_cycles;

	gf_poly_mul_top #(.DEPTH(DEPTH), .POLY(POLY)) gf_poly_mul_top_i (
		.clk       (clk),
		.rst_b     (rst_b),
		.start     (start),
		.a_we      (a_we),
		.b_we      (b_we),
		.load_addr (load_addr),
		.load_data (load_data),
		.c_rd_addr (c_rd_addr),
		.busy      (busy),
		.done      (done),
		.c_data    (c_data)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT) begin
			$display("timeout after %0d clock cycles, the run never finished", TIMEOUT);
			$display("Test FAILED");
			$fatal(1, "simulation stopped by timeout");
		end
	end

	// ------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------

	// carry-less product first, then reduce from the top bit down
	function automatic coef_t field_mul(input coef_t a, input coef_t b);
		logic [2*COEF_W-2:0] prod;
		prod = '0;
		for (int k = 0; k < COEF_W; k++)
			if (b[k])
				prod = prod ^ ((2*COEF_W-1)'(a) << k);
		for (int k = 2*COEF_W-2; k >= COEF_W; k--)
			if (prod[k])
				prod = prod ^ ((2*COEF_W-1)'({1'b1, POLY}) << (k-COEF_W));
		return prod[COEF_W-1:0];
	endfunction

	// coefficient k of the product is the XOR over all p+q == k
	function automatic word_t ref_word(input int w);
		coef_t coef [LANES];
		int k;
		for (int l = 0; l < LANES; l++) begin
			k = w*LANES + l;
			coef[l] = '0;
			for (int p = 0; p < NCOEF; p++)
				if (k - p >= 0 && k - p < NCOEF)
					coef[l] = coef[l] ^ field_mul(a_coef[p], b_coef[k-p]);
		end
		return {coef[1], coef[0]};	// lane 0 in the low bits
	endfunction

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	task automatic next_edge();
		@(posedge clk);
		#1;
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("FAILED %s expected %h actual %h", name, expected, actual);
			$display("Test FAILED");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	task automatic random_operands();
		for (int k = 0; k < NCOEF; k++) begin
			a_coef[k] = coef_t'($urandom);
			b_coef[k] = coef_t'($urandom);
		end
	endtask

	task automatic expect_reference();
		for (int w = 0; w < CWORDS; w++)
			exp_c[w] = ref_word(w);
	endtask

	task automatic load_operands();
		for (int w = 0; w < DEPTH; w++) begin
			a_we      = 1'b1;
			load_addr = AW'(w);
			load_data = {a_coef[2*w+1], a_coef[2*w]};
			next_edge();
		end
		a_we = 1'b0;
		for (int w = 0; w < DEPTH; w++) begin
			b_we      = 1'b1;
			load_addr = AW'(w);
			load_data = {b_coef[2*w+1], b_coef[2*w]};
			next_edge();
		end
		b_we = 1'b0;
	endtask

	// restart_at < 0 means no extra start pulse during the run
	task automatic run_product(input int restart_at);
		start = 1'b1;
		next_edge();	// this edge samples start
		start = 1'b0;
		run_cycles = 0;
		while (!done) begin
			check_value("busy during run", 32'd1, 32'(busy));
			start = (run_cycles == restart_at);
			next_edge();
			run_cycles++;
		end
		start = (restart_at >= 0);	// busy still covers the done cycle
		check_value("busy at done", 32'd1, 32'(busy));
		next_edge();
		start = 1'b0;
		check_value("done pulse width", 32'd0, 32'(done));
		check_value("busy after done", 32'd0, 32'(busy));
	endtask

	task automatic read_check(input string name);
		for (int w = 0; w < CWORDS; w++) begin
			c_rd_addr = CW'(w);
			@(negedge clk);	// read port is combinational
			check_value($sformatf("%s word %0d", name, w), 32'(exp_c[w]), 32'(c_data));
			next_edge();
		end
	endtask

	task automatic exercise(input string name, input int restart_at);
		load_operands();
		run_product(restart_at);
		check_value({name, " latency"}, 32'(LATENCY), 32'(run_cycles));
		read_check(name);
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		void'($urandom(32'h0ae9a062));
		rst_b     = 1'b0;
		start     = 1'b0;
		a_we      = 1'b0;
		b_we      = 1'b0;
		load_addr = '0;
		load_data = '0;
		c_rd_addr = '0;
		repeat (8) @(posedge clk);
		#1;
		rst_b = 1'b1;

		// quiet outputs before any start
		for (int n = 0; n < 4; n++) begin
			check_value("idle busy", 32'd0, 32'(busy));
			check_value("idle done", 32'd0, 32'(done));
			next_edge();
		end

		for (int t = 0; t < 10; t++) begin
			random_operands();
			expect_reference();
			exercise($sformatf("random_%0d", t), -1);
		end

		// A = 1 copies B into the low words
		random_operands();
		for (int k = 0; k < NCOEF; k++)
			a_coef[k] = '0;
		a_coef[0] = 8'h01;
		for (int w = 0; w < CWORDS; w++)
			exp_c[w] = (w < DEPTH) ? {b_coef[2*w+1], b_coef[2*w]} : '0;
		exercise("a_is_one", -1);

		for (int k = 0; k < NCOEF; k++)
			a_coef[k] = '0;
		for (int w = 0; w < CWORDS; w++)
			exp_c[w] = '0;
		exercise("a_is_zero", -1);

		// second run must not see the first product
		random_operands();
		expect_reference();
		exercise("first_of_two", -1);
		random_operands();
		expect_reference();
		exercise("second_of_two", -1);

		random_operands();
		expect_reference();
		exercise("restart_ignored", 5);	// extra start while busy

		$display("Test OK");
		$finish;
	end

endmodule

//--- rtl/gf_poly_mul_top.sv
`timescale 1ns/1ns

module gf_poly_mul_top #(
	parameter int                 DEPTH = 4,
	parameter gf_poly_pkg::coef_t POLY  = 8'h1B	// x^8+x^4+x^3+x+1
) (
	input  logic                        clk,
	input  logic                        rst_b,
	input  logic                        start,
	input  logic                        a_we,
	input  logic                        b_we,
	input  logic [$clog2(DEPTH)-1:0]    load_addr,
	input  gf_poly_pkg::word_t          load_data,
	input  logic [$clog2(2*DEPTH)-1:0]  c_rd_addr,
	output logic                        busy,
	output logic                        done,
	output gf_poly_pkg::word_t          c_data
);

	import gf_poly_pkg::*;

	localparam int AW = $clog2(DEPTH);
	localparam int CW = $clog2(2*DEPTH);

	logic clear;
	logic acc_en;
	logic [CW-1:0] acc_base;
	logic [AW-1:0] a_rd_addr;
	logic [AW-1:0] b_rd_addr;
	word_t a_word;
	word_t b_word;
	word_t row_prod [LANES];	// one row per A lane

	// ------------------------------------------------------------
	// operand memories and control
	// ------------------------------------------------------------
	operand_store #(.DEPTH(DEPTH)) operand_store_i (
		.clk       (clk),
		.rst_b     (rst_b),
		.a_we      (a_we),
		.b_we      (b_we),
		.load_addr (load_addr),
		.load_data (load_data),
		.a_rd_addr (a_rd_addr),
		.b_rd_addr (b_rd_addr),
		.a_word    (a_word),
		.b_word    (b_word)
	);

	mac_sequencer #(.DEPTH(DEPTH)) mac_sequencer_i (
		.clk       (clk),
		.rst_b     (rst_b),
		.start     (start),
		.busy      (busy),
		.done      (done),
		.clear     (clear),
		.a_rd_addr (a_rd_addr),
		.b_rd_addr (b_rd_addr),
		.acc_en    (acc_en),
		.acc_base  (acc_base)
	);

	// ------------------------------------------------------------
	// multiplier rows and accumulator
	// ------------------------------------------------------------
	for (genvar l = 0; l < LANES; l++) begin : g_row
		gf_row_mul #(.POLY(POLY)) gf_row_mul_i (
			.a_coef   (a_word[l*COEF_W +: COEF_W]),
			.b_word   (b_word),
			.row_prod (row_prod[l])
		);
	end

	diag_accum #(.DEPTH(DEPTH)) diag_accum_i (
		.clk       (clk),
		.rst_b     (rst_b),
		.clear     (clear),
		.acc_en    (acc_en),
		.acc_base  (acc_base),
		.row0      (row_prod[0]),
		.row1      (row_prod[1]),
		.c_rd_addr (c_rd_addr),
		.c_data    (c_data)
	);

endmodule

//--- rtl/diag_accum.sv
`timescale 1ns/1ns

module diag_accum #(
	parameter int DEPTH = 4
) (
	input  logic                        clk,
	input  logic                        rst_b,
	input  logic                        clear,
	input  logic                        acc_en,
	input  logic [$clog2(2*DEPTH)-1:0]  acc_base,
	input  gf_poly_pkg::word_t          row0,
	input  gf_poly_pkg::word_t          row1,
	input  logic [$clog2(2*DEPTH)-1:0]  c_rd_addr,
	output gf_poly_pkg::word_t          c_data
);

	import gf_poly_pkg::*;

	localparam int CW     = $clog2(2*DEPTH);
	localparam int CDEPTH = 2*DEPTH;	// product needs twice the words

	word_t c_mem [CDEPTH];
	coef_t d0;
	coef_t d1;
	coef_t d2;
	logic [CW-1:0] hi_addr;
	word_t lo_word;
	word_t hi_word;

	// ------------------------------------------------------------
	// diagonal sums of the 2x2 product grid
	// ------------------------------------------------------------
	assign d0 = row0[0 +: COEF_W];
	assign d1 = row0[COEF_W +: COEF_W] ^ row1[0 +: COEF_W];
	assign d2 = row1[COEF_W +: COEF_W];	// spills into next word

	assign hi_addr = acc_base + 1'b1;

	// read side sees the previous write already
	assign lo_word = c_mem[acc_base] ^ {d1, d0};
	assign hi_word = c_mem[hi_addr] ^ {{((LANES-1)*COEF_W){1'b0}}, d2};

	always_ff @(posedge clk) begin
		if (!rst_b || clear) begin
			for (int k = 0; k < CDEPTH; k++)
				c_mem[k] <= '0;
		end else if (acc_en) begin
			c_mem[acc_base] <= lo_word;
			c_mem[hi_addr]  <= hi_word;	// lane 0 only changes
		end
	end

	assign c_data = c_mem[c_rd_addr];	// combinational read-back

endmodule

//--- rtl/gf_row_mul.sv
`timescale 1ns/1ns

module gf_row_mul #(
	parameter gf_poly_pkg::coef_t POLY = 8'h1B
) (
	input  gf_poly_pkg::coef_t  a_coef,
	input  gf_poly_pkg::word_t  b_word,
	output gf_poly_pkg::word_t  row_prod
);

	import gf_poly_pkg::*;

	coef_t b_lane [LANES];
	coef_t p_lane [LANES];

	// ------------------------------------------------------------
	// one row of the multiplier grid
	// a single A coefficient against every lane of the B word
	// ------------------------------------------------------------
	for (genvar l = 0; l < LANES; l++) begin : g_lane
		assign b_lane[l] = b_word[l*COEF_W +: COEF_W];

		// purely combinational
		assign p_lane[l] = gf_mul(a_coef, b_lane[l], POLY);

		assign row_prod[l*COEF_W +: COEF_W] = p_lane[l];	// keep lane order
	end

endmodule

//--- rtl/mac_sequencer.sv
`timescale 1ns/1ns

module mac_sequencer #(
	parameter int DEPTH = 4
) (
	input  logic                        clk,
	input  logic                        rst_b,
	input  logic                        start,
	output logic                        busy,
	output logic                        done,
	output logic                        clear,
	output logic [$clog2(DEPTH)-1:0]    a_rd_addr,
	output logic [$clog2(DEPTH)-1:0]    b_rd_addr,
	output logic                        acc_en,
	output logic [$clog2(2*DEPTH)-1:0]  acc_base
);

	import gf_poly_pkg::*;

	localparam int AW = $clog2(DEPTH);
	localparam int CW = $clog2(2*DEPTH);

	seq_state_t state;
	seq_state_t state_nxt;
	logic [AW-1:0] i_cnt;	// A word index
	logic [AW-1:0] j_cnt;	// B word index, steps fastest
	logic drain_cnt;
	logic last_pair;
	logic issue;

	assign issue     = (state == RUN);
	assign last_pair = (i_cnt == AW'(DEPTH-1)) && (j_cnt == AW'(DEPTH-1));
	assign clear     = (state == CLEAR);
	assign busy      = (state != IDLE) || done;	// covers the done cycle too
	assign a_rd_addr = i_cnt;
	assign b_rd_addr = j_cnt;

	// ------------------------------------------------------------
	// next state
	// ------------------------------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			IDLE:  if (start && !done) state_nxt = CLEAR;
			CLEAR: state_nxt = RUN;
			RUN:   if (last_pair) state_nxt = DRAIN;
			DRAIN: if (drain_cnt) state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_b) begin
			state     <= IDLE;
			i_cnt     <= '0;
			j_cnt     <= '0;
			drain_cnt <= 1'b0;
			done      <= 1'b0;
			acc_en    <= 1'b0;
			acc_base  <= '0;
		end else begin
			state     <= state_nxt;
			drain_cnt <= (state == DRAIN) && !drain_cnt;
			done      <= (state == DRAIN) && drain_cnt;	// end of drain
			acc_en    <= issue;	// lines up with read data
			acc_base  <= CW'(i_cnt) + CW'(j_cnt);
			if (clear || (issue && last_pair)) begin
				i_cnt <= '0;
				j_cnt <= '0;
			end else if (issue) begin
				if (j_cnt == AW'(DEPTH-1)) begin
					j_cnt <= '0;
					i_cnt <= i_cnt + 1'b1;
				end else begin
					j_cnt <= j_cnt + 1'b1;
				end
			end
		end
	end

endmodule

//--- rtl/operand_store.sv
`timescale 1ns/1ns

module operand_store #(
	parameter int DEPTH = 4
) (
	input  logic                      clk,
	input  logic                      rst_b,
	input  logic                      a_we,
	input  logic                      b_we,
	input  logic [$clog2(DEPTH)-1:0]  load_addr,
	input  gf_poly_pkg::word_t        load_data,
	input  logic [$clog2(DEPTH)-1:0]  a_rd_addr,
	input  logic [$clog2(DEPTH)-1:0]  b_rd_addr,
	output gf_poly_pkg::word_t        a_word,
	output gf_poly_pkg::word_t        b_word
);

	import gf_poly_pkg::*;

	word_t a_mem [DEPTH];	// operand A, word i holds coefs 2i and 2i+1
	word_t b_mem [DEPTH];	// operand B

	// load port, one array per strobe
	always_ff @(posedge clk) begin
		if (a_we)
			a_mem[load_addr] <= load_data;
		if (b_we)
			b_mem[load_addr] <= load_data;
	end

	// ------------------------------------------------------------
	// registered reads, block RAM style
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_b) begin
			a_word <= '0;
			b_word <= '0;
		end else begin
			a_word <= a_mem[a_rd_addr];	// one cycle latency
			b_word <= b_mem[b_rd_addr];
		end
	end

endmodule

//--- rtl/gf_poly_pkg.sv
package gf_poly_pkg;

	localparam int COEF_W = 8;	// bits per GF(2^8) element
	localparam int LANES  = 2;	// coefficients per memory word

	typedef logic [COEF_W-1:0] coef_t;

	// lane 0 holds the lower-degree coefficient, in the low bits
	typedef logic [LANES*COEF_W-1:0] word_t;

	typedef enum logic [1:0] {
		IDLE,
		CLEAR,
		RUN,
		DRAIN
	} seq_state_t;

	// ------------------------------------------------------------
	// shift-and-add multiply, reduced on the fly
	// poly is the field polynomial without its x^8 term
	// ------------------------------------------------------------
	function automatic coef_t gf_mul(input coef_t a, input coef_t b, input coef_t poly);
		coef_t acc;
		coef_t sh;
		acc = '0;
		sh  = a;
		for (int k = 0; k < COEF_W; k++) begin
			if (b[k])
				acc = acc ^ sh;
			sh = sh[COEF_W-1] ? ((sh << 1) ^ poly) : (sh << 1);	// x*sh mod p
		end
		return acc;
	endfunction

endpackage
